/* source/wb_pkg.sv */
package wb_pkg;

    // target of one result slot
    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_gpr  = 2'd1,
        kind_seg  = 2'd2,
        kind_mem  = 2'd3
    } wb_kind_e;

    // control flow class of the retiring instruction
    typedef enum logic [1:0] {
        flow_plain  = 2'd0,
        flow_branch = 2'd1, // near jump or jcc
        flow_far    = 2'd2, // loads CS and EIP together
        flow_halt   = 2'd3
    } wb_flow_e;

    // one result slot, 102 bits
    typedef struct packed {
        logic        wr_en;
        wb_kind_e    kind;
        logic [2:0]  idx;   // gpr or segment number
        logic [31:0] addr;  // linear address for memory slots
        logic [63:0] data;
    } wb_slot_t;

    // one retiring instruction
    typedef struct packed {
        logic                valid;
        logic [31:0]         eip;
        logic [31:0]         fall_eip; // eip of the next sequential instruction
        logic [1:0]          op_size;
        logic [3:0]          size_ovr; // one-hot memory size override
        wb_flow_e            flow;
        wb_slot_t [3:0]      slot;
    } wb_bundle_t;

    // branch outcome from execute
    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        correct;  // prediction matched
        logic [31:0] fip;
        logic [31:0] fip_p1;   // fip plus one fetch line
    } wb_branch_t;

    // register or segment write port
    typedef struct packed {
        logic        en;
        logic [2:0]  idx;
        logic [31:0] data;
    } wb_reg_wr_t;

    // pending memory write
    typedef struct packed {
        logic [31:0] addr;
        logic [63:0] data;
        logic [1:0]  size; // log2 of byte count
    } wb_store_t;

    // fetch redirect
    typedef struct packed {
        logic        resteer;
        logic [31:0] new_fip_e;
        logic [31:0] new_fip_o;
        logic [31:0] new_eip;
    } wb_redirect_t;

    // exception report, ie_type[3] marks an interrupt
    typedef struct packed {
        logic       valid;
        logic [3:0] ie_type;
    } wb_ie_t;

endpackage

/* source/wb_result_router.sv */
`timescale 1ns/1ps

module wb_result_router #(
    parameter int num_slots = 4
) (
    input  wb_pkg::wb_bundle_t                   bundle,
    input  logic                                 ie_active,
    input  logic                                 queue_full,
    output logic                                 valid_out,
    output logic                                 stall,
    output wb_pkg::wb_reg_wr_t [num_slots-1:0]   gpr_wr,
    output wb_pkg::wb_reg_wr_t [num_slots-1:0]   seg_wr,
    output logic                                 push,
    output wb_pkg::wb_store_t                    push_data
);

    logic                 far;
    logic [num_slots-1:0] mem_hit;  // slots asking for a store
    logic [1:0]           mem_size;

    assign far = (bundle.flow == wb_pkg::flow_far);

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            mem_hit[i] = bundle.valid && bundle.slot[i].wr_en &&
                         (bundle.slot[i].kind == wb_pkg::kind_mem);
        end
    end

    // a store that meets a full queue holds the whole instruction
    assign stall     = (|mem_hit) & queue_full;
    assign valid_out = bundle.valid & ~stall & ~ie_active;
    assign push      = valid_out & (|mem_hit);

    // override first, then far transfer, then op size
    always_comb begin
        mem_size = bundle.op_size;
        if (|bundle.size_ovr) begin
            for (int k = 3; k >= 0; k--) begin
                if (bundle.size_ovr[k]) mem_size = 2'(k); // lowest set bit wins
            end
        end else if (far) begin
            mem_size = 2'd3;
        end
    end

    // one store per instruction, lowest slot taken
    always_comb begin
        push_data = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                push_data.addr = bundle.slot[i].addr;
                push_data.data = bundle.slot[i].data;
            end
        end
        push_data.size = mem_size;
    end

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            gpr_wr[i].en   = valid_out && bundle.slot[i].wr_en &&
                             (bundle.slot[i].kind == wb_pkg::kind_gpr);
            gpr_wr[i].idx  = bundle.slot[i].idx;
            gpr_wr[i].data = bundle.slot[i].data[31:0];

            seg_wr[i].en   = valid_out && bundle.slot[i].wr_en &&
                             (bundle.slot[i].kind == wb_pkg::kind_seg);
            seg_wr[i].idx  = bundle.slot[i].idx;
            seg_wr[i].data = bundle.slot[i].data[31:0];
            // far jmp/call carries the CS selector above the offset
            if (far && i == 0) begin
                seg_wr[i].data = {16'h0000, bundle.slot[i].data[47:32]};
            end
        end
    end

endmodule

/* source/wb_arch_regs.sv */
`timescale 1ns/1ps

module wb_arch_regs #(
    parameter int num_slots = 4,
    parameter int num_gprs  = 8,
    parameter int num_segs  = 6
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  wb_pkg::wb_reg_wr_t [num_slots-1:0]   gpr_wr,
    input  wb_pkg::wb_reg_wr_t [num_slots-1:0]   seg_wr,
    input  logic [$clog2(num_gprs)-1:0]          gpr_rd_addr,
    output logic [31:0]                          gpr_rd_data,
    input  logic [$clog2(num_segs)-1:0]          seg_rd_addr,
    output logic [15:0]                          seg_rd_data
);

    logic [31:0] gprs [num_gprs];
    logic [15:0] segs [num_segs];

    // later slots overwrite earlier ones on the same index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < num_gprs; r++) begin
                gprs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < num_slots; i++) begin
                if (gpr_wr[i].en && int'(gpr_wr[i].idx) < num_gprs) begin
                    gprs[gpr_wr[i].idx] <= gpr_wr[i].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < num_segs; r++) begin
                segs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < num_slots; i++) begin
                // indices 6 and 7 name no segment register
                if (seg_wr[i].en && int'(seg_wr[i].idx) < num_segs) begin
                    segs[seg_wr[i].idx] <= seg_wr[i].data[15:0];
                end
            end
        end
    end

    assign gpr_rd_data = gprs[gpr_rd_addr];

    always_comb begin
        seg_rd_data = '0;
        if (int'(seg_rd_addr) < num_segs) begin
            seg_rd_data = segs[seg_rd_addr];
        end
    end

endmodule

/* source/wb_store_queue.sv */
`timescale 1ns/1ps

module wb_store_queue #(
    parameter int queue_depth = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  wb_pkg::wb_store_t push_data,
    output logic              full,
    output logic              mem_req_valid,
    output wb_pkg::wb_store_t mem_req,
    input  logic              mem_ack
);

    localparam int ptr_w = $clog2(queue_depth);
    localparam int cnt_w = $clog2(queue_depth + 1);

    wb_pkg::wb_store_t  entries [queue_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign full          = (count == cnt_w'(queue_depth));
    assign mem_req_valid = (count != '0);
    assign mem_req       = entries[rd_ptr]; // oldest store, stable until acked

    assign do_pop  = mem_ack & mem_req_valid;
    assign do_push = push & (~full | do_pop); // room opens when the head leaves

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

endmodule

/* source/wb_control_flow.sv */
`timescale 1ns/1ps

module wb_control_flow (
    input  logic                 clk,
    input  logic                 arst_n,
    input  wb_pkg::wb_bundle_t   bundle,
    input  wb_pkg::wb_branch_t   branch,
    input  logic                 ie,
    input  logic [2:0]           ie_type,
    input  logic                 interrupt,
    input  logic                 valid_out,
    output logic                 ie_active,
    output wb_pkg::wb_redirect_t redirect,
    output wb_pkg::wb_ie_t       ie_out,
    output logic [31:0]          arch_eip,
    output logic                 halt_flop
);

    logic        far;
    logic        taken;
    logic [31:0] target_eip;
    logic [31:0] line_a;   // aligned target line
    logic [31:0] line_b;   // aligned next line
    logic [3:0]  last_ie_type;

    assign far   = (bundle.flow == wb_pkg::flow_far);
    assign taken = branch.valid & branch.taken;

    // exception or interrupt only counts with a live instruction
    assign ie_active = bundle.valid & (ie | interrupt);

    // far transfer takes its offset from slot 0, selector goes to CS
    assign target_eip = far ? bundle.slot[0].data[31:0] : branch.fip;

    assign line_a = {branch.fip[31:4], 4'h0};
    assign line_b = {branch.fip_p1[31:4], 4'h0};

    always_comb begin
        redirect.resteer = valid_out & branch.valid & ~branch.correct;
        redirect.new_eip = taken ? target_eip : bundle.fall_eip;
        // bit 4 of the target picks which bank holds it
        if (branch.fip[4]) begin
            redirect.new_fip_e = line_b;
            redirect.new_fip_o = line_a;
        end else begin
            redirect.new_fip_e = line_a;
            redirect.new_fip_o = line_b;
        end
    end

    // type holds the last cause between reports
    always_comb begin
        ie_out.valid   = ie_active;
        ie_out.ie_type = ie_active ? {interrupt, ie_type} : last_ie_type;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arch_eip     <= '0;
            halt_flop    <= 1'b0;
            last_ie_type <= '0;
        end else begin
            if (valid_out) begin
                arch_eip <= redirect.new_eip; // committed eip
            end
            if (valid_out && bundle.flow == wb_pkg::flow_halt) begin
                halt_flop <= 1'b1; // sticky until reset
            end
            if (ie_active) begin
                last_ie_type <= {interrupt, ie_type};
            end
        end
    end

endmodule

/* source/wb_stage_top.sv */
`timescale 1ns/1ps

module wb_stage_top #(
    parameter int num_slots   = 4,
    parameter int queue_depth = 4,
    parameter int num_gprs    = 8,
    parameter int num_segs    = 6
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  wb_pkg::wb_bundle_t            bundle,
    input  wb_pkg::wb_branch_t            branch,
    input  logic                          ie,
    input  logic [2:0]                    ie_type,
    input  logic                          interrupt,
    input  logic                          mem_ack,
    input  logic [$clog2(num_gprs)-1:0]   gpr_rd_addr,
    input  logic [$clog2(num_segs)-1:0]   seg_rd_addr,
    output logic                          mem_req_valid,
    output wb_pkg::wb_store_t             mem_req,
    output logic                          valid_out,
    output logic                          stall,
    output wb_pkg::wb_redirect_t          redirect,
    output wb_pkg::wb_ie_t                ie_out,
    output logic [31:0]                   arch_eip,
    output logic                          halt_flop,
    output logic [31:0]                   gpr_rd_data,
    output logic [15:0]                   seg_rd_data
);

    logic                               ie_active;
    logic                               queue_full;
    logic                               push;
    wb_pkg::wb_store_t                  push_data;
    wb_pkg::wb_reg_wr_t [num_slots-1:0] gpr_wr;
    wb_pkg::wb_reg_wr_t [num_slots-1:0] seg_wr;

    wb_result_router #(.num_slots(num_slots)) router_inst (
        .bundle(bundle), .ie_active(ie_active), .queue_full(queue_full),
        .valid_out(valid_out), .stall(stall), .gpr_wr(gpr_wr), .seg_wr(seg_wr),
        .push(push), .push_data(push_data)
    );

    wb_arch_regs #(.num_slots(num_slots), .num_gprs(num_gprs), .num_segs(num_segs)) regs_inst (
        .clk(clk), .arst_n(arst_n), .gpr_wr(gpr_wr), .seg_wr(seg_wr),
        .gpr_rd_addr(gpr_rd_addr), .gpr_rd_data(gpr_rd_data),
        .seg_rd_addr(seg_rd_addr), .seg_rd_data(seg_rd_data)
    );

    wb_store_queue #(.queue_depth(queue_depth)) queue_inst (
        .clk(clk), .arst_n(arst_n), .push(push), .push_data(push_data),
        .full(queue_full), .mem_req_valid(mem_req_valid), .mem_req(mem_req),
        .mem_ack(mem_ack)
    );

    wb_control_flow flow_inst (
        .clk(clk), .arst_n(arst_n), .bundle(bundle), .branch(branch),
        .ie(ie), .ie_type(ie_type), .interrupt(interrupt), .valid_out(valid_out),
        .ie_active(ie_active), .redirect(redirect), .ie_out(ie_out),
        .arch_eip(arch_eip), .halt_flop(halt_flop)
    );

endmodule

/* test/wb_stage_assertions.sv */
`timescale 1ns/1ps

module wb_stage_assertions #(
    parameter int num_slots = 4
) (
    input logic                               clk,
    input logic                               arst_n,
    input logic                               valid_out,
    input logic                               stall,
    input logic                               mem_req_valid,
    input wb_pkg::wb_store_t                  mem_req,
    input logic                               mem_ack,
    input wb_pkg::wb_redirect_t               redirect,
    input wb_pkg::wb_ie_t                     ie_out,
    input logic                               halt_flop,
    input logic                               push,
    input wb_pkg::wb_reg_wr_t [num_slots-1:0] gpr_wr,
    input wb_pkg::wb_reg_wr_t [num_slots-1:0] seg_wr
);

    int   fail_count = 0;
    logic any_wr;  // any register, segment or store commit this cycle

    always_comb begin
        any_wr = push;
        for (int i = 0; i < num_slots; i++) begin
            any_wr = any_wr | gpr_wr[i].en | seg_wr[i].en;
        end
    end

    // head of the queue waits for its ack
    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_ack |=> mem_req_valid && $stable(mem_req))
    else begin
        fail_count++;
        $error("mem_req changed or dropped before mem_ack");
    end

    stall_blocks: assert property (@(posedge clk) stall |-> !valid_out)
    else begin
        fail_count++;
        $error("valid_out high during stall");
    end

    ie_no_commit: assert property (@(posedge clk) ie_out.valid |-> !any_wr)
    else begin
        fail_count++;
        $error("a write committed while ie_out.valid was high");
    end

    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halt_flop |=> halt_flop)
    else begin
        fail_count++;
        $error("halt_flop fell without reset");
    end

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !valid_out && !stall &&
        !mem_req_valid && !redirect.resteer && !ie_out.valid && !halt_flop)
    else begin
        fail_count++;
        $error("control output high during reset");
    end

endmodule

bind wb_stage_top wb_stage_assertions assertions_inst (
    .clk(clk), .arst_n(arst_n), .valid_out(valid_out), .stall(stall),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_ack(mem_ack),
    .redirect(redirect), .ie_out(ie_out), .halt_flop(halt_flop), .push(push),
    .gpr_wr(gpr_wr), .seg_wr(seg_wr)
);

/* test/wb_stage_tb.sv */
`timescale 1ns/1ps

module wb_stage_tb;

    localparam int num_tests   = 400;
    localparam int cycle_bound = 16;  // worst case per instruction with stalls
    localparam int queue_depth = 4;

    logic clk, arst_n, ie, interrupt, mem_ack;
    logic mem_req_valid, valid_out, stall, halt_flop;
    logic [2:0]  ie_type, gpr_rd_addr, seg_rd_addr;
    logic [31:0] arch_eip, gpr_rd_data;
    logic [15:0] seg_rd_data;
    wb_pkg::wb_bundle_t   bundle;
    wb_pkg::wb_branch_t   branch;
    wb_pkg::wb_store_t    mem_req;
    wb_pkg::wb_redirect_t redirect;
    wb_pkg::wb_ie_t       ie_out;

    logic [31:0]       lfsr = 32'heb2;
    logic [31:0]       gpr_m [8];
    logic [15:0]       seg_m [6];
    wb_pkg::wb_store_t store_q [$];  // pushed and not yet acked
    logic [31:0]       eip_m;
    logic              halt_m;
    logic [3:0]        last_ie_m;    // cause of the most recent report
    int                checks, errors, assert_fails;

    wb_stage_top #(.num_slots(4), .queue_depth(queue_depth), .num_gprs(8), .num_segs(6))
        wb_stage_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci with taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic make_instr(input int n, output wb_pkg::wb_bundle_t b,
                              output wb_pkg::wb_branch_t br);
        logic [3:0] f;
        b.valid    = (3'(rand_bits(3)) != 3'd0);
        b.eip      = 32'(rand_bits(32));
        b.fall_eip = b.eip + 32'(rand_bits(4)) + 32'd1;
        b.op_size  = 2'(rand_bits(2));
        b.size_ovr = (rand_bits(1) != 0) ? (4'b0001 << 2'(rand_bits(2))) : 4'b0000;
        f = 4'(rand_bits(4));
        if (f < 4'd10)                         b.flow = wb_pkg::flow_plain;
        else if (f < 4'd13)                    b.flow = wb_pkg::flow_branch;
        else if (f < 4'd15)                    b.flow = wb_pkg::flow_far;
        else if (n > num_tests * 3 / 4)        b.flow = wb_pkg::flow_halt; // only late in the run
        else                                   b.flow = wb_pkg::flow_plain;
        for (int i = 0; i < 4; i++) begin
            b.slot[i].wr_en = (3'(rand_bits(3)) != 3'd0);
            b.slot[i].kind  = wb_pkg::wb_kind_e'(2'(rand_bits(2)));
            b.slot[i].idx   = 3'(rand_bits(3));
            b.slot[i].addr  = 32'(rand_bits(32));
            b.slot[i].data  = rand_bits(64);
        end
        br.valid   = 1'(rand_bits(1));
        br.taken   = 1'(rand_bits(1));
        br.correct = 1'(rand_bits(1));
        br.fip     = 32'(rand_bits(32));
        br.fip_p1  = br.fip + 32'd16;
    endtask

    // compare outputs and then advance the model to the coming edge
    task automatic check_cycle(output logic exp_stall);
        logic              has_mem, far, ie_act, exp_valid;
        logic [31:0]       exp_eip, line_a, line_b;
        wb_pkg::wb_store_t st;
        has_mem = 1'b0;
        st = '0;
        for (int i = 3; i >= 0; i--) begin
            if (bundle.valid && bundle.slot[i].wr_en &&
                bundle.slot[i].kind == wb_pkg::kind_mem) begin
                has_mem = 1'b1;
                st.addr = bundle.slot[i].addr;  // lowest slot ends up here
                st.data = bundle.slot[i].data;
            end
        end
        far       = (bundle.flow == wb_pkg::flow_far);
        ie_act    = bundle.valid && (ie || interrupt);
        exp_stall = has_mem && store_q.size() == queue_depth;
        exp_valid = bundle.valid && !exp_stall && !ie_act;
        if (bundle.size_ovr != 4'b0000) begin
            for (int k = 3; k >= 0; k--) if (bundle.size_ovr[k]) st.size = 2'(k);
        end else begin
            st.size = far ? 2'd3 : bundle.op_size;
        end
        exp_eip = !(branch.valid && branch.taken) ? bundle.fall_eip :
                  far ? bundle.slot[0].data[31:0] : branch.fip;
        line_a  = {branch.fip[31:4], 4'h0};
        line_b  = {branch.fip_p1[31:4], 4'h0};
        check_value("stall", 64'(stall), 64'(exp_stall));
        check_value("valid_out", 64'(valid_out), 64'(exp_valid));
        check_value("ie_out.valid", 64'(ie_out.valid), 64'(ie_act));
        check_value("ie_out.ie_type", 64'(ie_out.ie_type),
                    64'(ie_act ? {interrupt, ie_type} : last_ie_m));
        if (ie_act) last_ie_m = {interrupt, ie_type};
        check_value("redirect.resteer", 64'(redirect.resteer),
                    64'(exp_valid && branch.valid && !branch.correct));
        check_value("redirect.new_eip", 64'(redirect.new_eip), 64'(exp_eip));
        // even bank gets the line with bit 4 clear
        check_value("redirect.new_fip_e", 64'(redirect.new_fip_e),
                    64'(!line_a[4] ? line_a : line_b));
        check_value("redirect.new_fip_o", 64'(redirect.new_fip_o),
                    64'(line_a[4] ? line_a : line_b));
        check_value("arch_eip", 64'(arch_eip), 64'(eip_m));
        check_value("halt_flop", 64'(halt_flop), 64'(halt_m));
        check_value("gpr_rd_data", 64'(gpr_rd_data), 64'(gpr_m[gpr_rd_addr]));
        check_value("seg_rd_data", 64'(seg_rd_data), 64'(seg_m[seg_rd_addr]));
        check_value("mem_req_valid", 64'(mem_req_valid), 64'(store_q.size() != 0));
        if (store_q.size() != 0) begin
            check_value("mem_req.addr", 64'(mem_req.addr), 64'(store_q[0].addr));
            check_value("mem_req.data", mem_req.data, store_q[0].data);
            check_value("mem_req.size", 64'(mem_req.size), 64'(store_q[0].size));
            if (mem_ack) void'(store_q.pop_front());
        end
        if (exp_valid) begin
            if (has_mem) store_q.push_back(st);
            for (int i = 0; i < 4; i++) begin
                if (bundle.slot[i].wr_en && bundle.slot[i].kind == wb_pkg::kind_gpr)
                    gpr_m[bundle.slot[i].idx] = bundle.slot[i].data[31:0];
                if (bundle.slot[i].wr_en && bundle.slot[i].kind == wb_pkg::kind_seg &&
                    bundle.slot[i].idx < 3'd6)
                    seg_m[bundle.slot[i].idx] = (far && i == 0) ? bundle.slot[i].data[47:32]
                                                                : bundle.slot[i].data[15:0];
            end
            eip_m = exp_eip;
            if (bundle.flow == wb_pkg::flow_halt) halt_m = 1'b1;
        end
    endtask

    initial begin
        #((num_tests * cycle_bound + 100) * 10);
        $display("timeout: the stage stopped making progress");
        $display("Errors found");
        $finish;
    end

    initial begin
        wb_pkg::wb_bundle_t b;
        wb_pkg::wb_branch_t br;
        logic               ie_now, int_now, stalled;
        logic [2:0]         typ;
        int                 held;
        arst_n = 1'b0;
        bundle = '0;
        branch = '0;
        {ie, interrupt, mem_ack, ie_type, gpr_rd_addr, seg_rd_addr} = '0;
        {checks, errors, eip_m, halt_m, last_ie_m} = '0;
        foreach (gpr_m[r]) gpr_m[r] = '0;
        foreach (seg_m[r]) seg_m[r] = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < num_tests + 8; n++) begin
            make_instr(n, b, br);
            if (n >= num_tests) b.valid = 1'b0;  // drain the queue at the end
            ie_now  = (5'(rand_bits(5)) == 5'd0);
            int_now = (5'(rand_bits(5)) == 5'd0);
            typ     = 3'(rand_bits(3));
            held    = 0;
            do begin
                @(posedge clk);
                bundle      <= b;
                branch      <= br;
                ie          <= ie_now;
                interrupt   <= int_now;
                ie_type     <= typ;
                // slow acks in alternate blocks of tests let the queue fill
                mem_ack     <= (held >= 4) || (((n / 50) % 2 == 0) ? (rand_bits(1) != 0)
                                                                   : (3'(rand_bits(3)) == 3'd0));
                gpr_rd_addr <= 3'(rand_bits(3));
                seg_rd_addr <= 3'(rand_bits(8) % 6);
                @(negedge clk);
                check_cycle(stalled);
                held++;
            end while (stalled);
        end
        assert_fails = wb_stage_top_inst.assertions_inst.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* wb_stage_top.f */
source/wb_pkg.sv
source/wb_result_router.sv
source/wb_arch_regs.sv
source/wb_store_queue.sv
source/wb_control_flow.sv
source/wb_stage_top.sv
test/wb_stage_assertions.sv
test/wb_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the writeback stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing --top-module wb_stage_tb -f wb_stage_top.f -o sim_wb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_wb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "simulation aborted, see sim.log"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }
